//--- list.f
src/tss_cmd_pkg.sv
src/tss_target_pkg.sv
src/tss_target_decode.sv
src/tss_command_parse.sv
dv/tss_command_parse_checker.sv
dv/tb_tss_command_parse.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := tb_tss_command_parse
FILELIST := list.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_tss_command_parse.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tss_command_parse;

        localparam int RESET_CYCLES = 8;
        localparam int MAX_ROWS     = 128;
        localparam int CTRL_PORT    = tss_target_pkg::NUM_PORTS - 1;

        logic                                       i_clk;
        logic                                       i_rst_n;
        logic [tss_cmd_pkg::CMD_W-1:0]              i_cmd;
        logic                                       i_cmd_wr;
        logic [tss_cmd_pkg::ADDR_W-1:0]             o_addr,   exp_addr;
        logic [tss_cmd_pkg::DATA_W-1:0]             o_wdata,  exp_wdata;
        logic                                       o_addr_fixed, exp_fixed;
        logic [tss_target_pkg::NUM_PORTS-1:0]       o_wr_ffi, o_rd_ffi, o_wr_dex, o_rd_dex;
        logic [tss_target_pkg::NUM_PORTS-1:0]       exp_wr_ffi, exp_rd_ffi, exp_wr_dex, exp_rd_dex;
        logic [tss_target_pkg::NUM_QGC-1:0]         o_wr_qgc, o_rd_qgc, exp_wr_qgc, exp_rd_qgc;
        logic o_wr_grm, o_rd_grm, o_wr_flt, o_rd_flt, o_wr_pcb, o_rd_pcb;
        logic exp_wr_grm, exp_rd_grm, exp_wr_flt, exp_rd_flt, exp_wr_pcb, exp_rd_pcb;

        ////////////////////
        // command table

        logic [tss_cmd_pkg::TGT_W-1:0]         tbl_tgt   [MAX_ROWS];
        logic                                  tbl_fixed [MAX_ROWS];
        logic [tss_cmd_pkg::OP_W-1:0]          tbl_op    [MAX_ROWS];
        logic [2:0]                            tbl_spare [MAX_ROWS];  // cmd[60:58]
        logic [tss_cmd_pkg::ADDR_W-1:0]        tbl_addr  [MAX_ROWS];
        logic [tss_cmd_pkg::DATA_W-1:0]        tbl_data  [MAX_ROWS];
        tss_target_pkg::tgt_class_e            tbl_class [MAX_ROWS];
        logic [tss_target_pkg::PORT_IDX_W-1:0] tbl_port  [MAX_ROWS];
        tss_target_pkg::acc_e                  tbl_acc   [MAX_ROWS];
        logic                                  tbl_gap   [MAX_ROWS];  // idle cycle after
        int                                    n_rows = 0;
        int                                    timeout_cycles = 0;
        int                                    cycle_count = 0;

        tss_command_parse UUT (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_cmd        (i_cmd),
                .i_cmd_wr     (i_cmd_wr),
                .o_addr       (o_addr),
                .o_wdata      (o_wdata),
                .o_addr_fixed (o_addr_fixed),
                .o_wr_ffi     (o_wr_ffi),
                .o_rd_ffi     (o_rd_ffi),
                .o_wr_dex     (o_wr_dex),
                .o_rd_dex     (o_rd_dex),
                .o_wr_qgc     (o_wr_qgc),
                .o_rd_qgc     (o_rd_qgc),
                .o_wr_grm     (o_wr_grm),
                .o_rd_grm     (o_rd_grm),
                .o_wr_flt     (o_wr_flt),
                .o_rd_flt     (o_rd_flt),
                .o_wr_pcb     (o_wr_pcb),
                .o_rd_pcb     (o_rd_pcb)
        );

        always #50 i_clk = ~i_clk;

        // target codes by block numbering with the control port on 0 and 1
        function automatic logic [tss_cmd_pkg::TGT_W-1:0] ffi_code(input int p);
                int code;
                code = (p == CTRL_PORT) ? 0 : 8 * (p + 1);
                return code[tss_cmd_pkg::TGT_W-1:0];
        endfunction

        function automatic logic [tss_cmd_pkg::TGT_W-1:0] dex_code(input int p);
                int code;
                code = (p == CTRL_PORT) ? 1 : 8 * (p + 1) + 1;
                return code[tss_cmd_pkg::TGT_W-1:0];
        endfunction

        function automatic logic [tss_cmd_pkg::TGT_W-1:0] qgc_code(input int p);
                int code;
                code = 8 * (p + 1) + 3;
                return code[tss_cmd_pkg::TGT_W-1:0];
        endfunction

        task automatic add_row(input logic [tss_cmd_pkg::TGT_W-1:0] tgt, input logic fixed,
                               input logic [tss_cmd_pkg::OP_W-1:0] op,
                               input tss_target_pkg::tgt_class_e cls, input int port,
                               input tss_target_pkg::acc_e acc, input logic gap);
                logic [31:0] r;
                r = $urandom;
                tbl_tgt[n_rows]   = tgt;
                tbl_fixed[n_rows] = fixed;
                tbl_op[n_rows]    = op;
                tbl_spare[n_rows] = r[31:29];
                tbl_addr[n_rows]  = r[tss_cmd_pkg::ADDR_W-1:0];
                tbl_data[n_rows]  = $urandom;
                tbl_class[n_rows] = cls;
                tbl_port[n_rows]  = port[tss_target_pkg::PORT_IDX_W-1:0];
                tbl_acc[n_rows]   = acc;
                tbl_gap[n_rows]   = gap;
                n_rows++;
        endtask

        task automatic build_table;
                for (int p = 0; p < tss_target_pkg::NUM_PORTS; p++) begin
                        add_row(ffi_code(p), 1'b1, tss_cmd_pkg::OP_WRITE, tss_target_pkg::TC_FFI,
                                p, tss_target_pkg::ACC_WR, 1'b0);
                        add_row(ffi_code(p), 1'b1, tss_cmd_pkg::OP_READ, tss_target_pkg::TC_FFI,
                                p, tss_target_pkg::ACC_RD, p == 3);
                        add_row(dex_code(p), 1'b1, tss_cmd_pkg::OP_WRITE, tss_target_pkg::TC_DEX,
                                p, tss_target_pkg::ACC_WR, 1'b0);
                        add_row(dex_code(p), 1'b1, tss_cmd_pkg::OP_READ, tss_target_pkg::TC_DEX,
                                p, tss_target_pkg::ACC_RD, p[0]);
                end
                for (int p = 0; p < tss_target_pkg::NUM_QGC; p++) begin
                        add_row(qgc_code(p), 1'b1, tss_cmd_pkg::OP_WRITE, tss_target_pkg::TC_QGC,
                                p, tss_target_pkg::ACC_WR, 1'b0);
                        add_row(qgc_code(p), 1'b1, tss_cmd_pkg::OP_READ, tss_target_pkg::TC_QGC,
                                p, tss_target_pkg::ACC_RD, 1'b0);
                end
                add_row(7'd120, 1'b1, 2'b00, tss_target_pkg::TC_FLT, 0,
                        tss_target_pkg::ACC_WR, 1'b0);
                add_row(7'd120, 1'b1, 2'b10, tss_target_pkg::TC_FLT, 0,
                        tss_target_pkg::ACC_RD, 1'b0);
                // grm in both address modes
                add_row(7'd122, 1'b1, 2'b00, tss_target_pkg::TC_GRM, 0,
                        tss_target_pkg::ACC_WR, 1'b0);
                add_row(7'd122, 1'b1, 2'b10, tss_target_pkg::TC_GRM, 0,
                        tss_target_pkg::ACC_RD, 1'b0);
                add_row(7'd122, 1'b0, 2'b00, tss_target_pkg::TC_GRM, 0,
                        tss_target_pkg::ACC_WR, 1'b1);
                add_row(7'd122, 1'b0, 2'b10, tss_target_pkg::TC_GRM, 0,
                        tss_target_pkg::ACC_RD, 1'b0);
                add_row(7'd121, 1'b1, 2'b10, tss_target_pkg::TC_PCB, 0,
                        tss_target_pkg::ACC_RD, 1'b0);
                add_row(7'd121, 1'b1, 2'b00, tss_target_pkg::TC_PCB, 0,
                        tss_target_pkg::ACC_NONE, 1'b1);
                // none of these may strobe
                add_row(ffi_code(0), 1'b1, 2'b01, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(dex_code(CTRL_PORT), 1'b1, 2'b11, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b1);
                add_row(7'd122, 1'b0, 2'b01, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd2,   1'b1, 2'b00, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd10,  1'b1, 2'b10, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd123, 1'b1, 2'b00, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd127, 1'b1, 2'b10, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(ffi_code(3), 1'b0, 2'b00, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(dex_code(CTRL_PORT), 1'b0, 2'b10, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(qgc_code(5), 1'b0, 2'b00, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd120, 1'b0, 2'b10, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b0);
                add_row(7'd121, 1'b0, 2'b10, tss_target_pkg::TC_NONE, 0,
                        tss_target_pkg::ACC_NONE, 1'b1);
        endtask

        ////////////////////
        // checking

        task automatic stop_run;
                $display("test failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_field(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                assert (got === exp) else begin
                        $display("FAILED at %0t ns: %s is %0h, expected %0h",
                                 $time, name, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_outputs;
                check_field("o_addr", 64'(o_addr), 64'(exp_addr));
                check_field("o_wdata", 64'(o_wdata), 64'(exp_wdata));
                check_field("o_addr_fixed", 64'(o_addr_fixed), 64'(exp_fixed));
                check_field("o_wr_ffi", 64'(o_wr_ffi), 64'(exp_wr_ffi));
                check_field("o_rd_ffi", 64'(o_rd_ffi), 64'(exp_rd_ffi));
                check_field("o_wr_dex", 64'(o_wr_dex), 64'(exp_wr_dex));
                check_field("o_rd_dex", 64'(o_rd_dex), 64'(exp_rd_dex));
                check_field("o_wr_qgc", 64'(o_wr_qgc), 64'(exp_wr_qgc));
                check_field("o_rd_qgc", 64'(o_rd_qgc), 64'(exp_rd_qgc));
                check_field("o_wr_grm", 64'(o_wr_grm), 64'(exp_wr_grm));
                check_field("o_rd_grm", 64'(o_rd_grm), 64'(exp_rd_grm));
                check_field("o_wr_flt", 64'(o_wr_flt), 64'(exp_wr_flt));
                check_field("o_rd_flt", 64'(o_rd_flt), 64'(exp_rd_flt));
                check_field("o_wr_pcb", 64'(o_wr_pcb), 64'(exp_wr_pcb));
                check_field("o_rd_pcb", 64'(o_rd_pcb), 64'(exp_rd_pcb));
        endtask

        // expected outputs for the cycle after this slot
        task automatic set_expected(input logic have_cmd, input int idx);
                logic [tss_target_pkg::PORT_IDX_W-1:0] port;
                logic                                  wr;
                logic                                  rd;
                {exp_wr_ffi, exp_rd_ffi, exp_wr_dex, exp_rd_dex} = '0;
                {exp_wr_qgc, exp_rd_qgc} = '0;
                {exp_wr_grm, exp_rd_grm, exp_wr_flt, exp_rd_flt, exp_wr_pcb, exp_rd_pcb} = '0;
                if (!have_cmd) begin
                        exp_addr  = '0;  // fixed flag holds
                        exp_wdata = '0;
                end else begin
                        exp_addr  = tbl_addr[idx];
                        exp_wdata = tbl_data[idx];
                        exp_fixed = tbl_fixed[idx];
                        port      = tbl_port[idx];
                        wr        = (tbl_acc[idx] == tss_target_pkg::ACC_WR);
                        rd        = (tbl_acc[idx] == tss_target_pkg::ACC_RD);
                        case (tbl_class[idx])
                                tss_target_pkg::TC_FFI: begin
                                        exp_wr_ffi[port] = wr;
                                        exp_rd_ffi[port] = rd;
                                end
                                tss_target_pkg::TC_DEX: begin
                                        exp_wr_dex[port] = wr;
                                        exp_rd_dex[port] = rd;
                                end
                                tss_target_pkg::TC_QGC: begin
                                        exp_wr_qgc[port[2:0]] = wr;
                                        exp_rd_qgc[port[2:0]] = rd;
                                end
                                tss_target_pkg::TC_GRM: {exp_wr_grm, exp_rd_grm} = {wr, rd};
                                tss_target_pkg::TC_FLT: {exp_wr_flt, exp_rd_flt} = {wr, rd};
                                tss_target_pkg::TC_PCB: {exp_wr_pcb, exp_rd_pcb} = {wr, rd};
                                default: ;
                        endcase
                end
        endtask

        // drive one slot and check what the previous slot left on the outputs
        task automatic run_slot(input logic have_cmd, input int idx);
                @(posedge i_clk);
                // idle slots keep a decodable command on the bus
                i_cmd    <= {tbl_op[idx], tbl_fixed[idx], tbl_spare[idx], tbl_tgt[idx],
                             tbl_addr[idx], tbl_data[idx]};
                i_cmd_wr <= have_cmd;
                @(negedge i_clk);
                check_outputs();
                set_expected(have_cmd, idx);
        endtask

        always @(posedge i_clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
                        stop_run();
                end
        end

        initial begin
                void'($urandom(32'ha090));
                i_clk    = 1'b0;
                i_rst_n  = 1'b0;
                i_cmd    = '0;
                i_cmd_wr = 1'b0;
                exp_fixed = 1'b0;
                set_expected(1'b0, 0);
                build_table();
                timeout_cycles = n_rows * 4 + RESET_CYCLES;

                repeat (RESET_CYCLES - 1) @(posedge i_clk);
                @(negedge i_clk);
                check_outputs();  // reset state
                @(posedge i_clk);
                i_rst_n <= 1'b1;

                for (int i = 0; i < n_rows; i++) begin
                        run_slot(1'b1, i);
                        if (tbl_gap[i]) begin
                                run_slot(1'b0, i);
                        end
                end
                run_slot(1'b0, 0);
                run_slot(1'b0, 0);

                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

//--- dv/tss_command_parse_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tss_command_parse_checker (
        input wire i_clk,
        input wire i_rst_n,
        input wire i_cmd_wr,
        // every strobe pin of the parser
        input wire [4*tss_target_pkg::NUM_PORTS+2*tss_target_pkg::NUM_QGC+5:0] i_strobes,
        input wire i_wr_pcb
);

        ////////////////////
        // strobe rules

        a_strobe_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $onehot0(i_strobes))
                else $error("more than one strobe high");

        a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !i_cmd_wr |=> (i_strobes == '0))
                else $error("strobe after a cycle without command");

        a_pcb_read_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !$rose(i_wr_pcb))
                else $error("write strobe to pcb");

endmodule

bind tss_command_parse tss_command_parse_checker u_checker (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_cmd_wr  (i_cmd_wr),
        .i_strobes ({o_wr_ffi, o_rd_ffi, o_wr_dex, o_rd_dex, o_wr_qgc, o_rd_qgc,
                     o_wr_grm, o_rd_grm, o_wr_flt, o_rd_flt, o_wr_pcb, o_rd_pcb}),
        .i_wr_pcb  (o_wr_pcb)
);

`default_nettype wire

//--- src/tss_command_parse.sv
`timescale 1ns/1ps
`default_nettype none

module tss_command_parse (
        input  wire                                  i_clk,
        input  wire                                  i_rst_n,

        input  wire  [tss_cmd_pkg::CMD_W-1:0]        i_cmd,
        input  wire                                  i_cmd_wr,

        output logic [tss_cmd_pkg::ADDR_W-1:0]       o_addr,
        output logic [tss_cmd_pkg::DATA_W-1:0]       o_wdata,
        output logic                                 o_addr_fixed,

        // bit 8 is the control port
        output logic [tss_target_pkg::NUM_PORTS-1:0] o_wr_ffi,
        output logic [tss_target_pkg::NUM_PORTS-1:0] o_rd_ffi,
        output logic [tss_target_pkg::NUM_PORTS-1:0] o_wr_dex,
        output logic [tss_target_pkg::NUM_PORTS-1:0] o_rd_dex,

        output logic [tss_target_pkg::NUM_QGC-1:0]   o_wr_qgc,
        output logic [tss_target_pkg::NUM_QGC-1:0]   o_rd_qgc,

        output logic                                 o_wr_grm,
        output logic                                 o_rd_grm,
        output logic                                 o_wr_flt,
        output logic                                 o_rd_flt,
        output logic                                 o_wr_pcb,
        output logic                                 o_rd_pcb
);

        tss_target_pkg::tgt_class_e            dec_class;
        logic [tss_target_pkg::PORT_IDX_W-1:0] dec_port;
        tss_target_pkg::acc_e                  dec_acc;

        logic                                  wr_hit;
        logic                                  rd_hit;
        logic [tss_target_pkg::NUM_PORTS-1:0]  port_sel;

        logic                                  is_ffi;
        logic                                  is_dex;
        logic                                  is_qgc;
        logic                                  is_grm;
        logic                                  is_flt;
        logic                                  is_pcb;

        ////////////////////
        // decode

        tss_target_decode u_decode (
                .i_cmd   (i_cmd),
                .o_class (dec_class),
                .o_port  (dec_port),
                .o_acc   (dec_acc)
        );

        // only a strobed command may raise a strobe
        assign wr_hit = i_cmd_wr && (dec_acc == tss_target_pkg::ACC_WR);
        assign rd_hit = i_cmd_wr && (dec_acc == tss_target_pkg::ACC_RD);

        assign is_ffi = (dec_class == tss_target_pkg::TC_FFI);
        assign is_dex = (dec_class == tss_target_pkg::TC_DEX);
        assign is_qgc = (dec_class == tss_target_pkg::TC_QGC);
        assign is_grm = (dec_class == tss_target_pkg::TC_GRM);
        assign is_flt = (dec_class == tss_target_pkg::TC_FLT);
        assign is_pcb = (dec_class == tss_target_pkg::TC_PCB);

        always_comb begin : port_onehot
                for (int p = 0; p < tss_target_pkg::NUM_PORTS; p++) begin
                        port_sel[p] = (int'(dec_port) == p);
                end
        end

        ////////////////////
        // output registers

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_addr       <= '0;
                        o_wdata      <= '0;
                        o_addr_fixed <= 1'b0;
                end else if (i_cmd_wr) begin
                        o_addr       <= i_cmd[tss_cmd_pkg::ADDR_LSB +: tss_cmd_pkg::ADDR_W];
                        o_wdata      <= i_cmd[tss_cmd_pkg::DATA_LSB +: tss_cmd_pkg::DATA_W];
                        o_addr_fixed <= i_cmd[tss_cmd_pkg::FIXED_BIT];
                end else begin
                        o_addr       <= '0;  // flag keeps last mode
                        o_wdata      <= '0;
                end
        end

        // strobes follow the hit every cycle, so each is one cycle wide
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_wr_ffi <= '0;
                        o_rd_ffi <= '0;
                        o_wr_dex <= '0;
                        o_rd_dex <= '0;
                        o_wr_qgc <= '0;
                        o_rd_qgc <= '0;
                        o_wr_grm <= 1'b0;
                        o_rd_grm <= 1'b0;
                        o_wr_flt <= 1'b0;
                        o_rd_flt <= 1'b0;
                        o_wr_pcb <= 1'b0;
                        o_rd_pcb <= 1'b0;
                end else begin
                        o_wr_ffi <= {tss_target_pkg::NUM_PORTS{wr_hit && is_ffi}} & port_sel;
                        o_rd_ffi <= {tss_target_pkg::NUM_PORTS{rd_hit && is_ffi}} & port_sel;
                        o_wr_dex <= {tss_target_pkg::NUM_PORTS{wr_hit && is_dex}} & port_sel;
                        o_rd_dex <= {tss_target_pkg::NUM_PORTS{rd_hit && is_dex}} & port_sel;

                        // qgc ports are 0..7 only
                        o_wr_qgc <= {tss_target_pkg::NUM_QGC{wr_hit && is_qgc}} &
                                    port_sel[tss_target_pkg::NUM_QGC-1:0];
                        o_rd_qgc <= {tss_target_pkg::NUM_QGC{rd_hit && is_qgc}} &
                                    port_sel[tss_target_pkg::NUM_QGC-1:0];

                        o_wr_grm <= wr_hit && is_grm;
                        o_rd_grm <= rd_hit && is_grm;
                        o_wr_flt <= wr_hit && is_flt;
                        o_rd_flt <= rd_hit && is_flt;
                        o_wr_pcb <= wr_hit && is_pcb;  // decoder never gives pcb a write
                        o_rd_pcb <= rd_hit && is_pcb;
                end
        end

endmodule

`default_nettype wire

//--- src/tss_target_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tss_target_decode (
        input  wire  [tss_cmd_pkg::CMD_W-1:0]         i_cmd,
        output tss_target_pkg::tgt_class_e            o_class,
        output logic [tss_target_pkg::PORT_IDX_W-1:0] o_port,
        output tss_target_pkg::acc_e                  o_acc
);

        logic [tss_cmd_pkg::TGT_W-1:0]         tgt;
        logic                                  fixed;
        logic [tss_cmd_pkg::OP_W-1:0]          op;

        tss_target_pkg::tgt_class_e            hit_class;
        logic [tss_target_pkg::PORT_IDX_W-1:0] hit_port;
        tss_target_pkg::acc_e                  op_acc;
        logic                                  fixed_ok;

        ////////////////////
        // field extract

        assign tgt   = i_cmd[tss_cmd_pkg::TGT_LSB +: tss_cmd_pkg::TGT_W];
        assign fixed = i_cmd[tss_cmd_pkg::FIXED_BIT];
        assign op    = i_cmd[tss_cmd_pkg::OP_LSB +: tss_cmd_pkg::OP_W];

        ////////////////////
        // target match

        always_comb begin : target_match
                hit_class = tss_target_pkg::TC_NONE;
                hit_port  = '0;

                // per-port blocks, codes never overlap
                for (int p = 0; p < tss_target_pkg::NUM_PORTS; p++) begin
                        if (tgt == tss_target_pkg::TGT_FFI[p]) begin
                                hit_class = tss_target_pkg::TC_FFI;
                                hit_port  = p[tss_target_pkg::PORT_IDX_W-1:0];
                        end
                        if (tgt == tss_target_pkg::TGT_DEX[p]) begin
                                hit_class = tss_target_pkg::TC_DEX;
                                hit_port  = p[tss_target_pkg::PORT_IDX_W-1:0];
                        end
                end

                for (int q = 0; q < tss_target_pkg::NUM_QGC; q++) begin
                        if (tgt == tss_target_pkg::TGT_QGC[q]) begin
                                hit_class = tss_target_pkg::TC_QGC;
                                hit_port  = q[tss_target_pkg::PORT_IDX_W-1:0];
                        end
                end

                // single-instance blocks
                if (tgt == tss_target_pkg::TGT_FLT) begin
                        hit_class = tss_target_pkg::TC_FLT;
                end else if (tgt == tss_target_pkg::TGT_PCB) begin
                        hit_class = tss_target_pkg::TC_PCB;
                end else if (tgt == tss_target_pkg::TGT_GRM) begin
                        hit_class = tss_target_pkg::TC_GRM;
                end
        end

        ////////////////////
        // opcode

        always_comb begin : opcode_decode
                case (op)
                        tss_cmd_pkg::OP_WRITE: op_acc = tss_target_pkg::ACC_WR;
                        tss_cmd_pkg::OP_READ:  op_acc = tss_target_pkg::ACC_RD;
                        default:               op_acc = tss_target_pkg::ACC_NONE;
                endcase
        end

        // grm takes either address mode, the rest need fixed
        assign fixed_ok = fixed || (hit_class == tss_target_pkg::TC_GRM);

        always_comb begin : result
                o_class = tss_target_pkg::TC_NONE;
                o_port  = '0;
                o_acc   = tss_target_pkg::ACC_NONE;

                if (fixed_ok && (hit_class != tss_target_pkg::TC_NONE)) begin
                        o_class = hit_class;
                        o_port  = hit_port;
                        o_acc   = op_acc;
                        if ((hit_class == tss_target_pkg::TC_PCB) &&
                            (op_acc == tss_target_pkg::ACC_WR)) begin
                                o_acc = tss_target_pkg::ACC_NONE;  // pcb is read only
                        end
                end
        end

endmodule

`default_nettype wire

//--- src/tss_target_pkg.sv
`default_nettype none

package tss_target_pkg;

        ////////////////////
        // port counts

        localparam int NUM_PORTS  = 9;  // data ports 0..7, control port 8
        localparam int NUM_QGC    = 8;  // gate control on data ports only
        localparam int PORT_IDX_W = 4;

        ////////////////////
        // target field codes

        // index is the port number, leftmost entry is port 8
        localparam logic [NUM_PORTS-1:0][tss_cmd_pkg::TGT_W-1:0] TGT_FFI = {
                7'd0,   // control port
                7'd64,
                7'd56,
                7'd48,
                7'd40,
                7'd32,
                7'd24,
                7'd16,
                7'd8
        };

        localparam logic [NUM_PORTS-1:0][tss_cmd_pkg::TGT_W-1:0] TGT_DEX = {
                7'd1,   // control port
                7'd65,
                7'd57,
                7'd49,
                7'd41,
                7'd33,
                7'd25,
                7'd17,
                7'd9
        };

        localparam logic [NUM_QGC-1:0][tss_cmd_pkg::TGT_W-1:0] TGT_QGC = {
                7'd67,
                7'd59,
                7'd51,
                7'd43,
                7'd35,
                7'd27,
                7'd19,
                7'd11
        };

        localparam logic [tss_cmd_pkg::TGT_W-1:0] TGT_FLT = 7'd120;  // flow lookup
        localparam logic [tss_cmd_pkg::TGT_W-1:0] TGT_PCB = 7'd121;  // read only
        localparam logic [tss_cmd_pkg::TGT_W-1:0] TGT_GRM = 7'd122;  // fixed bit optional

        ////////////////////
        // decode results

        typedef enum logic [2:0] {
                TC_NONE,
                TC_FFI,
                TC_DEX,
                TC_QGC,
                TC_GRM,
                TC_FLT,
                TC_PCB
        } tgt_class_e;

        typedef enum logic [1:0] {
                ACC_NONE,
                ACC_WR,
                ACC_RD
        } acc_e;

endpackage

`default_nettype wire

//--- src/tss_cmd_pkg.sv
`default_nettype none

package tss_cmd_pkg;

        ////////////////////
        // command word widths

        localparam int CMD_W     = 64;
        localparam int ADDR_W    = 19;
        localparam int DATA_W    = 32;

        ////////////////////
        // field positions

        localparam int DATA_LSB  = 0;   // cmd[31:0]
        localparam int ADDR_LSB  = 32;  // cmd[50:32]
        localparam int TGT_LSB   = 51;  // cmd[57:51]
        localparam int TGT_W     = 7;

        // cmd[60:58] carry nothing the parser uses
        localparam int FIXED_BIT = 61;  // fixed-address flag

        localparam int OP_LSB    = 62;  // cmd[63:62]
        localparam int OP_W      = 2;

        ////////////////////
        // opcode

        // only two codes are defined, 2'b01 and 2'b11 are
        // accepted on the bus but raise no strobe
        typedef enum logic [OP_W-1:0] {
                OP_WRITE = 2'b00,
                OP_READ  = 2'b10
        } cmd_op_e;

endpackage

`default_nettype wire
